// File: source/proc_pkg.sv
/*
 * Shared definitions for the pipelined core: widths, opcodes, ALU codes,
 * special registers, exception codes, the instruction word and decode helpers
 */
package proc_pkg;

    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int opcode_width   = 5;
    localparam int imm_width      = 17;
    localparam int target_width   = 27;

    // Opcodes
    localparam logic [opcode_width-1:0] op_rtype = 5'b00000;
    localparam logic [opcode_width-1:0] op_j     = 5'b00001;
    localparam logic [opcode_width-1:0] op_bne   = 5'b00010;
    localparam logic [opcode_width-1:0] op_jal   = 5'b00011;
    localparam logic [opcode_width-1:0] op_jr    = 5'b00100;
    localparam logic [opcode_width-1:0] op_addi  = 5'b00101;
    localparam logic [opcode_width-1:0] op_blt   = 5'b00110;
    localparam logic [opcode_width-1:0] op_sw    = 5'b00111;
    localparam logic [opcode_width-1:0] op_lw    = 5'b01000;
    localparam logic [opcode_width-1:0] op_setx  = 5'b10101;
    localparam logic [opcode_width-1:0] op_bex   = 5'b10110;

    // ALU function field of R type instructions
    localparam logic [4:0] alu_add = 5'b00000;
    localparam logic [4:0] alu_sub = 5'b00001;
    localparam logic [4:0] alu_and = 5'b00010;
    localparam logic [4:0] alu_or  = 5'b00011;
    localparam logic [4:0] alu_sll = 5'b00100;
    localparam logic [4:0] alu_sra = 5'b00101;

    localparam logic [reg_addr_width-1:0] reg_status = 5'd30;
    localparam logic [reg_addr_width-1:0] reg_link   = 5'd31;

    // Status codes written to r30 on overflow
    localparam logic [word_width-1:0] exc_add  = 32'd1;
    localparam logic [word_width-1:0] exc_addi = 32'd2;
    localparam logic [word_width-1:0] exc_sub  = 32'd3;

    // Operand bypass selects
    localparam logic [1:0] fwd_none = 2'd0;
    localparam logic [1:0] fwd_mem  = 2'd1;
    localparam logic [1:0] fwd_wb   = 2'd2;

    typedef struct packed {
        logic [opcode_width-1:0]   opcode;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [4:0]                shamt;
        logic [4:0]                alu_op;
        logic [1:0]                zero;
    } r_fields_t;

    typedef struct packed {
        logic [opcode_width-1:0]   opcode;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs;
        logic [imm_width-1:0]      imm;
    } i_fields_t;

    typedef struct packed {
        logic [opcode_width-1:0] opcode;
        logic [target_width-1:0] target;
    } ji_fields_t;

    typedef union packed {
        r_fields_t  r;
        i_fields_t  i;
        ji_fields_t ji;
    } instr_t;

    // Instruction reads rs as its first operand
    function automatic logic uses_rs(instr_t ir);
        return ir.r.opcode inside {op_rtype, op_addi, op_sw, op_lw, op_bne, op_blt};
    endfunction

    // Instruction reads a second register
    function automatic logic uses_b(instr_t ir);
        return ir.r.opcode inside {op_rtype, op_sw, op_bne, op_blt, op_jr, op_bex};
    endfunction

    // Second register: rt for R type, r30 for bex, rd otherwise
    function automatic logic [reg_addr_width-1:0] b_reg(instr_t ir);
        if (ir.r.opcode == op_rtype)
            return ir.r.rt;
        if (ir.r.opcode == op_bex)
            return reg_status;
        return ir.r.rd;
    endfunction

    // rd is a real destination once jal, setx and exceptions are rewritten
    function automatic logic writes_rd(instr_t ir);
        return ir.r.opcode inside {op_rtype, op_addi, op_lw, op_jal, op_setx};
    endfunction

endpackage

// File: source/alu.sv
/*
 * Integer ALU with not-equal, signed less-than and signed overflow flags
 */
`timescale 1ns/1ps

module alu import proc_pkg::*; (
    input  logic [word_width-1:0] a,
    input  logic [word_width-1:0] b,
    input  logic [4:0]            alu_op,
    input  logic [4:0]            shamt,
    output logic [word_width-1:0] result,
    output logic                  not_equal,
    output logic                  less_than,
    output logic                  overflow
);

    localparam int msb = word_width - 1;

    logic [word_width-1:0] sum;
    logic [word_width-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (alu_op)
            alu_add: result = sum;
            alu_sub: result = diff;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_sll: result = a << shamt;
            alu_sra: result = $signed(a) >>> shamt;
            default: result = '0;
        endcase
    end

    assign not_equal = a != b;
    assign less_than = $signed(a) < $signed(b);

    // Sign of the result disagrees with what the operand signs allow
    assign overflow = (alu_op == alu_sub) ?
                      (a[msb] != b[msb]) && (diff[msb] != a[msb]) :
                      (a[msb] == b[msb]) && (sum[msb] != a[msb]);

endmodule

// File: source/fetch_stage.sv
/*
 * Program counter, next PC selection and the fetch/decode register
 */
`timescale 1ns/1ps

module fetch_stage import proc_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [word_width-1:0] target_pc,
    input  instr_t                q_imem,
    output logic [word_width-1:0] address_imem,
    output logic [word_width-1:0] fd_pc,
    output instr_t                fd_ir
);

    logic [word_width-1:0] pc;
    logic [word_width-1:0] pc_plus_one;

    assign pc_plus_one  = pc + word_width'(1);
    assign address_imem = pc;

    // fd_pc is the address after the fetched word, the base for branch targets and links
    always_ff @(posedge clock) begin
        if (reset) begin
            pc    <= '0;
            fd_pc <= '0;
            fd_ir <= '0;
        end else if (flush || !stall) begin
            pc    <= flush ? target_pc : pc_plus_one;
            fd_pc <= pc_plus_one;
            // Word fetched behind a taken branch is dropped
            fd_ir <= flush ? '0 : q_imem;
        end
    end

    // Load-use stall from decode must freeze the fetch address
    assert property (@(posedge clock) disable iff (reset)
        stall |=> $stable(pc) && $stable(fd_ir));

endmodule

// File: source/reg_file.sv
/*
 * 32 by 32 register file, r0 reads zero, writes visible to same-cycle reads
 */
`timescale 1ns/1ps

module reg_file import proc_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      write_enable,
    input  logic [reg_addr_width-1:0] write_reg,
    input  logic [reg_addr_width-1:0] rs_addr,
    input  logic [reg_addr_width-1:0] rt_addr,
    input  logic [word_width-1:0]     write_data,
    output logic [word_width-1:0]     rs_data,
    output logic [word_width-1:0]     rt_data
);

    logic [word_width-1:0] regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (write_enable && write_reg != '0) begin
            regs[write_reg] <= write_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rs_data = (write_enable && write_reg == rs_addr && rs_addr != '0) ?
                     write_data : regs[rs_addr];
    assign rt_data = (write_enable && write_reg == rt_addr && rt_addr != '0) ?
                     write_data : regs[rt_addr];

    assert property (@(posedge clock) disable iff (reset) regs[0] == '0);

endmodule

// File: source/decode_stage.sv
/*
 * Register read selection, load-use hazard detection and the decode/execute register
 */
`timescale 1ns/1ps

module decode_stage import proc_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      flush,
    input  logic [word_width-1:0]     fd_pc,
    input  instr_t                    fd_ir,
    input  logic [word_width-1:0]     rs_data,
    input  logic [word_width-1:0]     rt_data,
    output logic [reg_addr_width-1:0] rs_addr,
    output logic [reg_addr_width-1:0] rt_addr,
    output logic                      stall,
    output logic [word_width-1:0]     dx_pc,
    output logic [word_width-1:0]     dx_a,
    output logic [word_width-1:0]     dx_b,
    output instr_t                    dx_ir
);

    logic dx_is_load;
    logic base_offset_zero;
    logic rs_hazard;
    logic b_hazard;

    assign rs_addr = fd_ir.r.rs;
    assign rt_addr = b_reg(fd_ir);

    // Load in execute whose result decode needs next cycle
    assign dx_is_load = dx_ir.r.opcode == op_lw && dx_ir.r.rd != '0;

    // A zero offset address is patched in memory from writeback
    assign base_offset_zero = (fd_ir.r.opcode inside {op_sw, op_lw}) && fd_ir.i.imm == '0;
    assign rs_hazard = uses_rs(fd_ir) && !base_offset_zero && fd_ir.r.rs == dx_ir.r.rd;

    // Store data is also patched in memory, so sw never waits on it
    assign b_hazard = uses_b(fd_ir) && fd_ir.r.opcode != op_sw && rt_addr == dx_ir.r.rd;

    assign stall = dx_is_load && (rs_hazard || b_hazard);

    always_ff @(posedge clock) begin
        if (reset || stall || flush) begin
            dx_pc <= '0;
            dx_a  <= '0;
            dx_b  <= '0;
            dx_ir <= '0;
        end else begin
            dx_pc <= fd_pc;
            dx_a  <= rs_data;
            dx_b  <= rt_data;
            dx_ir <= fd_ir;
        end
    end

endmodule

// File: source/forward_unit.sv
/*
 * Bypass selection for execute operands and for memory-stage address and store data
 */
`timescale 1ns/1ps

module forward_unit import proc_pkg::*; (
    input  instr_t     dx_ir,
    input  instr_t     xm_ir,
    input  instr_t     mw_ir,
    output logic [1:0] sel_a,
    output logic [1:0] sel_b,
    output logic       sw_data_fwd,
    output logic       addr_fwd
);

    logic [reg_addr_width-1:0] m_rd;
    logic [reg_addr_width-1:0] w_rd;
    logic [reg_addr_width-1:0] b_src;
    logic                      m_writes;
    logic                      w_writes;

    assign m_rd  = xm_ir.r.rd;
    assign w_rd  = mw_ir.r.rd;
    assign b_src = b_reg(dx_ir);

    // A load in memory has only its address so far, hence the stall
    assign m_writes = writes_rd(xm_ir) && xm_ir.r.opcode != op_lw && m_rd != '0;
    assign w_writes = writes_rd(mw_ir) && w_rd != '0;

    // Memory is younger than writeback and wins
    always_comb begin
        sel_a = fwd_none;
        if (uses_rs(dx_ir) && m_writes && m_rd == dx_ir.r.rs)
            sel_a = fwd_mem;
        else if (uses_rs(dx_ir) && w_writes && w_rd == dx_ir.r.rs)
            sel_a = fwd_wb;

        sel_b = fwd_none;
        if (uses_b(dx_ir) && m_writes && m_rd == b_src)
            sel_b = fwd_mem;
        else if (uses_b(dx_ir) && w_writes && w_rd == b_src)
            sel_b = fwd_wb;
    end

    // Loaded value reaching a store right behind the load
    assign sw_data_fwd = xm_ir.r.opcode == op_sw && w_writes && w_rd == m_rd;

    // Zero offset means the address is the base register itself
    assign addr_fwd = (xm_ir.r.opcode inside {op_sw, op_lw}) && xm_ir.i.imm == '0 &&
                      w_writes && w_rd == xm_ir.r.rs;

endmodule

// File: source/execute_stage.sv
/*
 * Operand bypass muxes, branch and jump resolution, exception and link rewriting,
 * and the execute/memory register
 */
`timescale 1ns/1ps

module execute_stage import proc_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [word_width-1:0] dx_pc,
    input  logic [word_width-1:0] dx_a,
    input  logic [word_width-1:0] dx_b,
    input  logic [word_width-1:0] xm_o_fwd,
    input  logic [word_width-1:0] write_data,
    input  instr_t                dx_ir,
    input  logic [1:0]            sel_a,
    input  logic [1:0]            sel_b,
    output logic                  branch_taken,
    output logic                  jump_taken,
    output logic [word_width-1:0] target_pc,
    output logic [word_width-1:0] xm_o,
    output logic [word_width-1:0] xm_b,
    output instr_t                xm_ir
);

    logic [opcode_width-1:0] op;
    logic [word_width-1:0]   a_fwd, b_fwd;
    logic [word_width-1:0]   alu_a, alu_b, alu_result;
    logic [word_width-1:0]   imm_ext, jump_target, x_o;
    logic [4:0]              alu_op;
    logic                    not_equal, less_than, overflow;
    logic                    is_add, is_sub, is_addi, exc_taken;
    instr_t                  x_ir;

    assign op = dx_ir.r.opcode;

    assign a_fwd = (sel_a == fwd_mem) ? xm_o_fwd : (sel_a == fwd_wb) ? write_data : dx_a;
    assign b_fwd = (sel_b == fwd_mem) ? xm_o_fwd : (sel_b == fwd_wb) ? write_data : dx_b;

    assign imm_ext     = {{(word_width - imm_width){dx_ir.i.imm[imm_width-1]}}, dx_ir.i.imm};
    assign jump_target = word_width'(dx_ir.ji.target);

    // bex compares r30 against zero
    assign alu_a  = (op == op_bex) ? '0 : a_fwd;
    assign alu_b  = (op inside {op_rtype, op_bne, op_blt, op_bex}) ? b_fwd : imm_ext;
    assign alu_op = (op == op_rtype) ? dx_ir.r.alu_op : alu_add;

    alu u_alu (
        .a         (alu_a),
        .b         (alu_b),
        .alu_op    (alu_op),
        .shamt     (dx_ir.r.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than),
        .overflow  (overflow)
    );

    // blt is taken when rd < rs, operand b is rd
    assign branch_taken = (op == op_bne && not_equal) ||
                          (op == op_blt && !less_than && not_equal);
    assign jump_taken   = (op inside {op_j, op_jal, op_jr}) || (op == op_bex && not_equal);

    // dx_pc already points one past this instruction
    assign target_pc = branch_taken ? dx_pc + imm_ext :
                       (op == op_jr) ? b_fwd : jump_target;

    assign is_add    = op == op_rtype && dx_ir.r.alu_op == alu_add;
    assign is_sub    = op == op_rtype && dx_ir.r.alu_op == alu_sub;
    assign is_addi   = op == op_addi;
    assign exc_taken = (is_add || is_sub || is_addi) && overflow;

    // Implicit destinations are folded into rd for forwarding and writeback
    always_comb begin
        x_ir = dx_ir;
        x_o  = alu_result;
        if (exc_taken) begin
            x_ir.r.rd = reg_status;
            x_o       = is_addi ? exc_addi : (is_sub ? exc_sub : exc_add);
        end else if (op == op_jal) begin
            x_ir.r.rd = reg_link;
            x_o       = dx_pc;
        end else if (op == op_setx) begin
            x_ir.r.rd = reg_status;
            x_o       = jump_target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            xm_ir <= '0;
            xm_o  <= '0;
            xm_b  <= '0;
        end else begin
            xm_ir <= x_ir;
            xm_o  <= x_o;
            xm_b  <= b_fwd;
        end
    end

    assert property (@(posedge clock) disable iff (reset) !(branch_taken && jump_taken));

endmodule

// File: source/mem_wb_stage.sv
/*
 * Data memory port with writeback bypass, memory/writeback register, write-back select
 */
`timescale 1ns/1ps

module mem_wb_stage import proc_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  instr_t                    xm_ir,
    input  logic [word_width-1:0]     xm_o,
    input  logic [word_width-1:0]     xm_b,
    input  logic [word_width-1:0]     q_dmem,
    input  logic                      sw_data_fwd,
    input  logic                      addr_fwd,
    output logic [word_width-1:0]     address_dmem,
    output logic [word_width-1:0]     data,
    output logic                      wren,
    output instr_t                    mw_ir,
    output logic                      write_enable,
    output logic [reg_addr_width-1:0] write_reg,
    output logic [word_width-1:0]     write_data
);

    logic [word_width-1:0] mw_o;
    logic [word_width-1:0] mw_d;

    assign address_dmem = addr_fwd ? write_data : xm_o;
    assign data         = sw_data_fwd ? write_data : xm_b;
    assign wren         = xm_ir.r.opcode == op_sw;

    always_ff @(posedge clock) begin
        if (reset) begin
            mw_ir <= '0;
            mw_o  <= '0;
            mw_d  <= '0;
        end else begin
            mw_ir <= xm_ir;
            mw_o  <= xm_o;
            mw_d  <= q_dmem;
        end
    end

    // Bubbles and r0 targets never write
    assign write_reg    = mw_ir.r.rd;
    assign write_enable = writes_rd(mw_ir) && mw_ir.r.rd != '0;
    assign write_data   = (mw_ir.r.opcode == op_lw) ? mw_d : mw_o;

    // Stores only, and bypassed address and data must be resolved by then
    assert property (@(posedge clock) disable iff (reset)
        wren |-> xm_ir.r.opcode == op_sw && !$isunknown({address_dmem, data}));

endmodule

// File: source/processor.sv
/*
 * Five-stage pipelined core top level with register file and forwarding
 */
`timescale 1ns/1ps

module processor import proc_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    output logic [word_width-1:0] address_imem,
    input  logic [word_width-1:0] q_imem,
    output logic [word_width-1:0] address_dmem,
    output logic [word_width-1:0] data,
    output logic                  wren,
    input  logic [word_width-1:0] q_dmem
);

    logic [word_width-1:0]     fd_pc, dx_pc, dx_a, dx_b, target_pc;
    logic [word_width-1:0]     xm_o, xm_b, rs_data, rt_data, write_data;
    logic [reg_addr_width-1:0] rs_addr, rt_addr, write_reg;
    logic [1:0]                sel_a, sel_b;
    logic                      stall, flush, branch_taken, jump_taken;
    logic                      sw_data_fwd, addr_fwd, write_enable;
    instr_t                    fd_ir, dx_ir, xm_ir, mw_ir;

    // Taken control transfer squashes the two younger instructions
    assign flush = branch_taken | jump_taken;

    fetch_stage u_fetch (
        .clock, .reset, .stall, .flush, .target_pc,
        .q_imem, .address_imem, .fd_pc, .fd_ir
    );

    decode_stage u_decode (
        .clock, .reset, .flush, .fd_pc, .fd_ir, .rs_data, .rt_data,
        .rs_addr, .rt_addr, .stall, .dx_pc, .dx_a, .dx_b, .dx_ir
    );

    reg_file u_reg_file (
        .clock, .reset, .write_enable, .write_reg, .rs_addr, .rt_addr,
        .write_data, .rs_data, .rt_data
    );

    execute_stage u_execute (
        .clock, .reset, .dx_pc, .dx_a, .dx_b,
        .xm_o_fwd (xm_o),
        .write_data, .dx_ir, .sel_a, .sel_b, .branch_taken, .jump_taken,
        .target_pc, .xm_o, .xm_b, .xm_ir
    );

    forward_unit u_forward (
        .dx_ir, .xm_ir, .mw_ir, .sel_a, .sel_b, .sw_data_fwd, .addr_fwd
    );

    mem_wb_stage u_mem_wb (
        .clock, .reset, .xm_ir, .xm_o, .xm_b, .q_dmem, .sw_data_fwd, .addr_fwd,
        .address_dmem, .data, .wren, .mw_ir, .write_enable, .write_reg, .write_data
    );

endmodule

// File: tests/tb_programs.svh
/*
 * Instruction encoders, test program words and the expected store table
 */

localparam int num_programs = 5;
localparam int max_words    = 24;
localparam int max_stores   = 10;

logic [31:0] prog_words [num_programs][max_words];
int          prog_len   [num_programs];
logic [31:0] exp_addr   [num_programs][max_stores];
logic [31:0] exp_data   [num_programs][max_stores];
int          exp_count  [num_programs];

function automatic logic [31:0] r_word(input logic [4:0] alu_op, input int rd, input int rs,
                                       input int rt, input int shamt);
    return {op_rtype, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], alu_op, 2'b00};
endfunction

function automatic logic [31:0] i_word(input logic [4:0] opcode, input int rd, input int rs,
                                       input int imm);
    return {opcode, rd[4:0], rs[4:0], imm[16:0]};
endfunction

function automatic logic [31:0] j_word(input logic [4:0] opcode, input int target);
    return {opcode, target[26:0]};
endfunction

task automatic emit(input int p, input logic [31:0] word);
    prog_words[p][prog_len[p]] = word;
    prog_len[p]++;
endtask

task automatic expect_store(input int p, input logic [31:0] addr, input logic [31:0] value);
    exp_addr[p][exp_count[p]] = addr;
    exp_data[p][exp_count[p]] = value;
    exp_count[p]++;
endtask

task automatic build_programs();
    for (int p = 0; p < num_programs; p++) begin
        prog_len[p]  = 0;
        exp_count[p] = 0;
        for (int w = 0; w < max_words; w++)
            prog_words[p][w] = '0;
    end

    // Dependent ALU chain, every operand bypassed from the previous result
    emit(0, i_word(op_addi, 1, 0, 7));
    emit(0, i_word(op_addi, 2, 1, 5));
    emit(0, r_word(alu_add, 3, 2, 1, 0));
    emit(0, r_word(alu_sub, 4, 3, 2, 0));
    emit(0, r_word(alu_and, 5, 4, 3, 0));
    emit(0, r_word(alu_or, 6, 5, 2, 0));
    emit(0, r_word(alu_sll, 7, 6, 0, 4));
    emit(0, i_word(op_addi, 8, 0, -256));
    emit(0, r_word(alu_sra, 9, 8, 0, 4));
    for (int r = 1; r <= 9; r++)
        emit(0, i_word(op_sw, r, 0, 15 + r));
    expect_store(0, 16, 32'd7);
    expect_store(0, 17, 32'd12);
    expect_store(0, 18, 32'd19);
    expect_store(0, 19, 32'd7);
    expect_store(0, 20, 32'd3);
    expect_store(0, 21, 32'd15);
    expect_store(0, 22, 32'h0000_00f0);
    expect_store(0, 23, 32'hffff_ff00);
    expect_store(0, 24, 32'hffff_fff0);

    // Store then reload, load-use stall, loaded value fed straight to a store
    emit(1, i_word(op_addi, 1, 0, 40));
    emit(1, i_word(op_addi, 2, 0, 100));
    emit(1, i_word(op_sw, 1, 2, 5));
    emit(1, i_word(op_lw, 3, 2, 5));
    emit(1, r_word(alu_add, 4, 3, 1, 0));
    emit(1, i_word(op_sw, 4, 2, 0));
    emit(1, i_word(op_lw, 5, 2, 0));
    emit(1, i_word(op_sw, 5, 2, 1));
    expect_store(1, 105, 32'd40);
    expect_store(1, 100, 32'd80);
    expect_store(1, 101, 32'd80);

    // Stores at 99..96 sit in flushed slots
    emit(2, i_word(op_addi, 1, 0, 1));
    emit(2, i_word(op_addi, 2, 0, 2));
    emit(2, i_word(op_bne, 1, 2, 2));
    emit(2, i_word(op_sw, 1, 0, 99));
    emit(2, i_word(op_sw, 2, 0, 98));
    emit(2, i_word(op_sw, 1, 0, 30));
    emit(2, i_word(op_bne, 1, 1, 2));
    emit(2, i_word(op_sw, 2, 0, 31));
    emit(2, i_word(op_blt, 1, 2, 2));
    emit(2, i_word(op_sw, 1, 0, 97));
    emit(2, i_word(op_sw, 2, 0, 96));
    emit(2, i_word(op_sw, 2, 0, 32));
    emit(2, i_word(op_blt, 2, 1, 2));
    emit(2, i_word(op_sw, 1, 0, 33));
    expect_store(2, 30, 32'd1);
    expect_store(2, 31, 32'd2);
    expect_store(2, 32, 32'd2);
    expect_store(2, 33, 32'd1);

    // Call at word 4 into 9, return to 5, then jump over the rest to 14
    emit(3, i_word(op_addi, 1, 0, 3));
    emit(3, j_word(op_j, 4));
    emit(3, i_word(op_sw, 1, 0, 90));
    emit(3, i_word(op_sw, 1, 0, 91));
    emit(3, j_word(op_jal, 9));
    emit(3, i_word(op_sw, 31, 0, 40));
    emit(3, j_word(op_j, 14));
    emit(3, i_word(op_sw, 1, 0, 92));
    emit(3, i_word(op_sw, 1, 0, 93));
    emit(3, i_word(op_sw, 1, 0, 41));
    emit(3, i_word(op_jr, 31, 0, 0));
    emit(3, i_word(op_sw, 1, 0, 94));
    emit(3, i_word(op_sw, 1, 0, 95));
    emit(3, '0);
    emit(3, i_word(op_sw, 1, 0, 42));
    expect_store(3, 41, 32'd3);
    expect_store(3, 40, 32'd5);
    expect_store(3, 42, 32'd3);

    // r4 is the largest positive word, r2 the most negative
    emit(4, i_word(op_addi, 1, 0, 1));
    emit(4, r_word(alu_sll, 2, 1, 0, 31));
    emit(4, i_word(op_addi, 3, 0, -1));
    emit(4, r_word(alu_sub, 4, 3, 2, 0));
    emit(4, i_word(op_addi, 5, 0, 9));
    emit(4, r_word(alu_add, 5, 4, 1, 0));
    emit(4, i_word(op_sw, 30, 0, 50));
    emit(4, i_word(op_addi, 5, 4, 1));
    emit(4, i_word(op_sw, 30, 0, 51));
    emit(4, r_word(alu_sub, 5, 2, 1, 0));
    emit(4, i_word(op_sw, 30, 0, 52));
    emit(4, i_word(op_sw, 5, 0, 53));
    emit(4, j_word(op_setx, 20));
    emit(4, j_word(op_bex, 16));
    emit(4, i_word(op_sw, 30, 0, 89));
    emit(4, i_word(op_sw, 30, 0, 88));
    emit(4, i_word(op_sw, 30, 0, 54));
    emit(4, j_word(op_setx, 0));
    emit(4, j_word(op_bex, 22));
    emit(4, i_word(op_sw, 30, 0, 55));
    emit(4, '0);
    emit(4, '0);
    emit(4, i_word(op_sw, 1, 0, 56));
    expect_store(4, 50, 32'd1);
    expect_store(4, 51, 32'd2);
    expect_store(4, 52, 32'd3);
    expect_store(4, 53, 32'd9);
    expect_store(4, 54, 32'd20);
    expect_store(4, 55, 32'd0);
    expect_store(4, 56, 32'd1);
endtask

// File: tests/processor_tb.sv
/*
 * Testbench for the pipelined core: clock, reset, memory models, program loop and checks
 */
`timescale 1ns/1ps

module processor_tb import proc_pkg::*; ();

    localparam int clock_half    = 20;
    localparam int drive_delay   = 1;
    localparam int imem_depth    = 64;
    localparam int dmem_depth    = 256;
    localparam int store_timeout = 100;

    logic        clock = 1'b0;
    logic        reset;
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data;
    logic        wren;
    logic [31:0] q_dmem;

    logic [31:0] imem [imem_depth];
    logic [31:0] dmem [dmem_depth];

    int checks;
    int mismatches;
    int timeouts;

    `include "tb_programs.svh"

    processor u_dut (
        .clock, .reset, .address_imem, .q_imem, .address_dmem, .data, .wren, .q_dmem
    );

    always #clock_half clock = ~clock;

    // Both memories answer in the same cycle, words past the program read as nops
    assign q_imem = (address_imem < imem_depth) ? imem[address_imem[5:0]] : '0;
    assign q_dmem = (address_dmem < dmem_depth) ? dmem[address_dmem[7:0]] : '0;

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < dmem_depth; i++)
                dmem[i] <= '0;
        end else if (wren && address_dmem < dmem_depth) begin
            dmem[address_dmem[7:0]] <= data;
        end
    end

    task automatic load_program(input int p);
        for (int i = 0; i < imem_depth; i++)
            imem[i] = (i < max_words) ? prog_words[p][i] : '0;
    endtask

    // Store outputs settle after the rising edge, so look at them mid-cycle
    task automatic next_store(output logic [31:0] got_addr, output logic [31:0] got_data,
                              output logic found);
        found = 1'b0;
        for (int c = 0; c < store_timeout && !found; c++) begin
            @(negedge clock);
            if (wren) begin
                got_addr = address_dmem;
                got_data = data;
                found    = 1'b1;
            end
        end
    endtask

    task automatic run_program(input int p);
        logic [31:0] got_addr;
        logic [31:0] got_data;
        logic        found;

        @(posedge clock);
        #drive_delay;
        reset = 1'b1;
        load_program(p);
        repeat (2) @(posedge clock);
        #drive_delay;
        reset = 1'b0;

        for (int k = 0; k < exp_count[p]; k++) begin
            next_store(got_addr, got_data, found);
            assert (found) else begin
                timeouts++;
                $display("Program %0d: expected store %0d never arrived", p, k);
            end
            if (!found)
                break;
            checks++;
            assert (got_addr == exp_addr[p][k]) else begin
                mismatches++;
                $display("FAIL address_dmem expected 0x%08h got 0x%08h (program %0d store %0d)",
                         exp_addr[p][k], got_addr, p, k);
            end
            assert (got_data == exp_data[p][k]) else begin
                mismatches++;
                $display("FAIL data expected 0x%08h got 0x%08h (program %0d store %0d)",
                         exp_data[p][k], got_data, p, k);
            end
        end
    endtask

    initial begin
        reset      = 1'b1;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        build_programs();
        load_program(0);

        for (int p = 0; p < num_programs; p++)
            run_program(p);

        $display("Stores checked: %0d, mismatches: %0d, timeouts: %0d",
                 checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: all.f
+incdir+tests
source/proc_pkg.sv
source/alu.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/forward_unit.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/processor.sv
tests/processor_tb.sv

// File: Bender.yml
package:
  name: pipelined_core

sources:
  - source/proc_pkg.sv
  - source/alu.sv
  - source/fetch_stage.sv
  - source/reg_file.sv
  - source/decode_stage.sv
  - source/forward_unit.sv
  - source/execute_stage.sv
  - source/mem_wb_stage.sv
  - source/processor.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/processor_tb.sv
